// File: mems_scan_pkg.sv
`default_nettype none

package mems_scan_pkg;

    // scan addressing
    localparam int SCAN_ADDR_W = 9;     // four positions per pattern entry
    localparam int ROM_AW      = 7;     // scan_addr >> 2
    localparam int ROM_DEPTH   = 128;
    localparam logic [ROM_AW-1:0] ROM_LAST = 7'd127;

    // word widths
    localparam int SAMPLE_W   = 16;
    localparam int DAC_WORD_W = 24;

    // dac commands
    localparam logic [DAC_WORD_W-1:0] SOFT_RESET_CMD = 24'h28_0001;
    localparam logic [DAC_WORD_W-1:0] VREF_CMD       = 24'h38_0000;  // internal ref on
    localparam logic [5:0]            DAC_WRITE_PREFIX = 6'b000110;  // write and update

    // trajectory and homing
    localparam logic [SAMPLE_W-1:0] ANTI_OFFSET = 16'hB900;  // mirror axis of the pattern
    localparam logic [SAMPLE_W-1:0] HOME_BIAS   = 16'd23250;
    localparam logic [SAMPLE_W-1:0] HOME_STEP   = 16'd30;

    localparam string PATTERN_FILE = "mirror_pattern.hex";

    // channel code as carried in scan_addr[2:1] and in the dac address field
    typedef enum logic [1:0] {
        CH_A = 2'd0,
        CH_C = 2'd1,    // mirrored
        CH_B = 2'd2,
        CH_D = 2'd3     // mirrored
    } channel_code_t;

endpackage

`default_nettype wire

// File: mirror_pattern_rom.sv
`default_nettype none

module mirror_pattern_rom (
    input  wire  [mems_scan_pkg::SCAN_ADDR_W-1:0] scan_addr,
    output logic [mems_scan_pkg::SAMPLE_W-1:0]    pattern_word
);
    import mems_scan_pkg::*;

    logic [SAMPLE_W-1:0] rom_q [ROM_DEPTH];
    logic [ROM_AW-1:0]   rom_idx;

    initial begin
        $readmemh(PATTERN_FILE, rom_q);
    end

    // one entry covers four positions, one per channel
    assign rom_idx = scan_addr[SCAN_ADDR_W-1:2];

    // async read, the bank samples it on the even edge
    assign pattern_word = rom_q[rom_idx];

endmodule

`default_nettype wire

// File: channel_bank.sv
`default_nettype none

module channel_bank (
    input  wire                                    addr,
    input  wire                                    rst,
    input  wire  [mems_scan_pkg::SCAN_ADDR_W-1:0]  scan_addr,
    input  wire                                    go_home,
    input  wire  [mems_scan_pkg::SAMPLE_W-1:0]     pattern_word,
    output logic [mems_scan_pkg::SAMPLE_W-1:0]     channel_value
);
    import mems_scan_pkg::*;

    channel_code_t       ch_sel;
    logic                even_pos;
    logic                mirrored;
    logic [SAMPLE_W-1:0] ch_q [4];      // indexed by channel code
    logic [SAMPLE_W-1:0] cur_value;
    logic [SAMPLE_W-1:0] traj_value;
    logic [SAMPLE_W-1:0] home_value;
    logic [SAMPLE_W-1:0] next_value;

    assign ch_sel   = channel_code_t'(scan_addr[2:1]);
    assign even_pos = ~scan_addr[0];
    assign mirrored = ch_sel[0];        // C and D, scan_addr[1] set

    assign cur_value = ch_q[ch_sel];

    // trajectory word, mirrored channels run the opposite way
    always_comb begin
        if (mirrored) begin
            traj_value = ANTI_OFFSET - pattern_word;    // wraps mod 2^16
        end else begin
            traj_value = pattern_word;
        end
    end

    // one step toward home per update
    always_comb begin
        if (cur_value > HOME_BIAS) begin
            home_value = cur_value - HOME_STEP;
        end else begin
            home_value = cur_value + HOME_STEP;     // also at the bias, so it dithers
        end
    end

    assign next_value = go_home ? home_value : traj_value;

    // only the selected channel moves, and only on even positions
    always_ff @(posedge addr) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                ch_q[i] <= HOME_BIAS;
            end
        end else if (even_pos) begin
            ch_q[ch_sel] <= next_value;
        end
    end

    // value before this edge, the encoder registers it on odd positions
    assign channel_value = cur_value;

endmodule

`default_nettype wire

// File: dac_frame_encoder.sv
`default_nettype none

module dac_frame_encoder (
    input  wire                                    addr,
    input  wire                                    rst,
    input  wire  [mems_scan_pkg::SCAN_ADDR_W-1:0]  scan_addr,
    input  wire  [mems_scan_pkg::SAMPLE_W-1:0]     channel_value,
    output logic [mems_scan_pkg::DAC_WORD_W-1:0]   data,
    output logic                                   scan_done
);
    import mems_scan_pkg::*;

    channel_code_t         ch_sel;
    logic [ROM_AW-1:0]     scan_idx;
    logic [DAC_WORD_W-1:0] data_d;
    logic                  scan_done_d;

    assign ch_sel   = channel_code_t'(scan_addr[2:1]);
    assign scan_idx = scan_addr[SCAN_ADDR_W-1:2];

    // even positions carry housekeeping, odd ones the channel write
    always_comb begin
        if (scan_addr == '0) begin
            data_d = SOFT_RESET_CMD;        // start of scan
        end else if (!scan_addr[0]) begin
            data_d = VREF_CMD;
        end else begin
            data_d = {DAC_WRITE_PREFIX, ch_sel, channel_value};
        end
    end

    // last entry spans positions 508..511
    assign scan_done_d = (scan_idx == ROM_LAST);

    always_ff @(posedge addr) begin
        if (rst) begin
            data      <= '0;
            scan_done <= 1'b0;
        end else begin
            data      <= data_d;
            scan_done <= scan_done_d;
        end
    end

endmodule

`default_nettype wire

// File: mems_scanner.sv
`default_nettype none

module mems_scanner (
    input  wire                                    addr,
    input  wire                                    rst,
    input  wire  [mems_scan_pkg::SCAN_ADDR_W-1:0]  scan_addr,
    input  wire                                    go_home,
    output logic [mems_scan_pkg::DAC_WORD_W-1:0]   data,
    output logic                                   scan_done
);
    import mems_scan_pkg::*;

    logic [SAMPLE_W-1:0] pattern_word;
    logic [SAMPLE_W-1:0] channel_value;

    // trajectory table, combinational
    mirror_pattern_rom mirror_pattern_rom_i (
        .scan_addr    (scan_addr),
        .pattern_word (pattern_word)
    );

    // channel state, updated on even positions
    channel_bank channel_bank_i (
        .addr          (addr),
        .rst           (rst),
        .scan_addr     (scan_addr),
        .go_home       (go_home),
        .pattern_word  (pattern_word),
        .channel_value (channel_value)
    );

    // one cycle to data and scan_done
    dac_frame_encoder dac_frame_encoder_i (
        .addr          (addr),
        .rst           (rst),
        .scan_addr     (scan_addr),
        .channel_value (channel_value),
        .data          (data),
        .scan_done     (scan_done)
    );

endmodule

`default_nettype wire

// File: mems_scanner_sva.sv
`default_nettype none

module mems_scanner_sva (
    input wire                                    addr,
    input wire                                    rst,
    input wire  [mems_scan_pkg::SCAN_ADDR_W-1:0]  scan_addr,
    input wire  [mems_scan_pkg::DAC_WORD_W-1:0]   data,
    input wire                                    scan_done
);
    timeunit 1ns;
    timeprecision 1ps;

    import mems_scan_pkg::*;

    // word registered under reset must be all zero
    reset_clears: assert property (@(posedge addr)
        $past(rst) |-> (data == '0 && !scan_done))
        else $error("data or scan_done not cleared by reset");

    // odd position always turns into a channel write
    write_prefix: assert property (@(posedge addr) disable iff (rst)
        scan_addr[0] |=> (data[DAC_WORD_W-1:DAC_WORD_W-6] == DAC_WRITE_PREFIX))
        else $error("channel write prefix missing after odd position");

    done_only_at_last: assert property (@(posedge addr) disable iff (rst)
        (scan_addr[SCAN_ADDR_W-1:2] != ROM_LAST) |=> !scan_done)
        else $error("scan_done raised outside the last pattern entry");

endmodule

bind mems_scanner mems_scanner_sva mems_scanner_sva_i (
    .addr      (addr),
    .rst       (rst),
    .scan_addr (scan_addr),
    .data      (data),
    .scan_done (scan_done)
);

`default_nettype wire

// File: tb_mems_scanner.sv
`default_nettype none

module tb_mems_scanner;
    timeunit 1ns;
    timeprecision 1ps;

    import mems_scan_pkg::*;

    localparam int SCAN_LEN   = 512;
    localparam int NUM_SCANS  = 3;
    localparam int RESET_CYC  = 2;
    localparam int MAX_CYCLES = NUM_SCANS * SCAN_LEN + RESET_CYC + 462;   // 2000 with margin

    logic                   addr;
    logic                   rst;
    logic [SCAN_ADDR_W-1:0] scan_addr;
    logic                   go_home;
    logic [DAC_WORD_W-1:0]  data;
    logic                   scan_done;

    logic [SAMPLE_W-1:0] model_rom [ROM_DEPTH];
    logic [SAMPLE_W-1:0] model_ch [4];     // by channel code
    logic [15:0]         lfsr_state;
    int                  cycle_count = 0;

    mems_scanner mems_scanner_i (
        .addr      (addr),
        .rst       (rst),
        .scan_addr (scan_addr),
        .go_home   (go_home),
        .data      (data),
        .scan_done (scan_done)
    );

    initial begin
        addr = 1'b0;
        forever #20 addr = ~addr;
    end

    always @(posedge addr) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    // drive one position at a falling edge, check the word one cycle later
    task automatic step_position(input logic [SCAN_ADDR_W-1:0] pos, input logic home,
                                 input string write_name);
        logic [1:0]            code;
        logic [ROM_AW-1:0]     idx;
        logic [SAMPLE_W-1:0]   cur;
        logic [DAC_WORD_W-1:0] exp_data;
        logic                  exp_done;
        string                 name;
        code      = pos[2:1];
        idx       = pos[SCAN_ADDR_W-1:2];
        cur       = model_ch[code];
        scan_addr = pos;
        go_home   = home;
        exp_done  = (idx == ROM_LAST);
        if (pos == '0) begin
            exp_data = SOFT_RESET_CMD;
            name     = "soft_reset";
        end else if (!pos[0]) begin
            exp_data = VREF_CMD;
            name     = "vref";
        end else begin
            exp_data = {DAC_WRITE_PREFIX, code, cur};   // value held before this edge
            name     = write_name;
        end
        if (!pos[0]) begin
            if (home) begin
                if (cur > HOME_BIAS) begin
                    model_ch[code] = cur - HOME_STEP;
                end else begin
                    model_ch[code] = cur + HOME_STEP;
                end
            end else if (code[0]) begin
                model_ch[code] = ANTI_OFFSET - model_rom[idx];  // mirrored channel
            end else begin
                model_ch[code] = model_rom[idx];
            end
        end
        @(negedge addr);
        check_value(name, 32'(exp_data), 32'(data));
        check_value("scan_done", 32'(exp_done), 32'(scan_done));
    endtask

    initial begin
        logic [15:0] bits;
        logic [15:0] home_bit;
        logic        home;
        rst        = 1'b1;
        scan_addr  = '0;
        go_home    = 1'b0;
        lfsr_state = 16'd48;
        for (int i = 0; i < 4; i++) begin
            model_ch[i] = HOME_BIAS;
        end
        $readmemh(PATTERN_FILE, model_rom);

        repeat (RESET_CYC) @(posedge addr);
        @(negedge addr);
        check_value("reset_data", 32'd0, 32'(data));
        check_value("reset_done", 32'd0, 32'(scan_done));
        rst = 1'b0;

        // scan 1, trajectory only
        for (int p = 0; p < SCAN_LEN; p++) begin
            step_position(SCAN_ADDR_W'(p), 1'b0, "trajectory_write");
        end

        // scan 2, homing switched on and off
        home = 1'b0;
        for (int p = 0; p < SCAN_LEN; p++) begin
            if (p % 8 == 0) begin
                take_bits(1, bits);
                if (bits[0]) begin
                    home = ~home;
                end
            end
            step_position(SCAN_ADDR_W'(p), home, "homing_write");
        end

        // scan 3, random positions
        for (int n = 0; n < SCAN_LEN; n++) begin
            take_bits(SCAN_ADDR_W, bits);
            take_bits(1, home_bit);
            step_position(bits[SCAN_ADDR_W-1:0], home_bit[0], "random_write");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: mirror_pattern.hex
// one 16-bit trajectory word per line, line n is pattern index n
// rising ramp over entries 0..63, falling ramp over 64..127
2000
2301
2602
2903
2C04
2F05
3206
3507
3808
3B09
3E0A
410B
440C
470D
4A0E
4D0F
5010
5311
5612
5913
5C14
5F15
6216
6517
6818
6B19
6E1A
711B
741C
771D
7A1E
7D1F
8020
8321
8622
8923
8C24
8F25
9226
9527
9828
9B29
9E2A
A12B
A42C
A72D
AA2E
AD2F
B030
B331
B632
B933
BC34
BF35
C236
C537
C838
CB39
CE3A
D13B
D43C
D73D
DA3E
DD3F
DD40
DA41
D742
D443
D144
CE45
CB46
C847
C548
C249
BF4A
BC4B
B94C
B64D
B34E
B04F
AD50
AA51
A752
A453
A154
9E55
9B56
9857
9558
9259
8F5A
8C5B
895C
865D
835E
805F
7D60
7A61
7762
7463
7164
6E65
6B66
6867
6568
6269
5F6A
5C6B
596C
566D
536E
506F
4D70
4A71
4772
4473
4174
3E75
3B76
3877
3578
3279
2F7A
2C7B
297C
267D
237E
207F

// File: mems_scanner.f
mems_scan_pkg.sv
mirror_pattern_rom.sv
channel_bank.sv
dac_frame_encoder.sv
mems_scanner.sv
mems_scanner_sva.sv
tb_mems_scanner.sv

// File: Makefile
TOP = tb_mems_scanner

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mems_scanner.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
